// File: compile.f
rtl/alu_pkg.sv
rtl/flags_pkg.sv
rtl/alu_op_if.sv
rtl/alu_addsub.sv
rtl/alu_bitlog.sv
rtl/alu_shift_rotate.sv
rtl/alu_muldiv.sv
rtl/alu_core.sv
rtl/alu_flags_reg.sv
rtl/alu_top.sv
verification/alu_tb.sv

// File: rtl/alu_addsub.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational adder and subtractor, byte or word wide.
// For INC and DEC the cf output is meaningless.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module alu_addsub (
  alu_op_if.unit ops,
  output logic [15:0] sum,
  output logic        cf,
  output logic        af,
  output logic        of
);
  import alu_pkg::*;

  logic [15:0] a, b, bx;
  logic        sub, cin;
  logic [16:0] full;
  logic [8:0]  low;

  always_comb begin
    a = ops.x[15:0];
    // INC and DEC behave as ADD and SUB of one without carry.
    b = (ops.op == OP_INC || ops.op == OP_DEC) ? 16'd1 : ops.y;
    sub = (ops.op == OP_SUB || ops.op == OP_SBB || ops.op == OP_DEC);
    bx = sub ? ~b : b;
    // Subtraction adds the inverted operand plus one, less any borrow.
    case (ops.op)
      OP_ADC:  cin = ops.cfi;
      OP_SBB:  cin = ~ops.cfi;
      default: cin = sub;
    endcase
    full = {1'b0, a} + {1'b0, bx} + {16'd0, cin};
    low  = {1'b0, a[7:0]} + {1'b0, bx[7:0]} + {8'd0, cin};
    sum = full[15:0];
    // A carry out means no borrow when subtracting.
    cf = (ops.word_op ? full[16] : low[8]) ^ sub;
    // Carry out of bit 3, taken with the true operand.
    af = a[4] ^ b[4] ^ full[4];
    if (ops.word_op)
      of = (a[15] == bx[15]) && (full[15] != a[15]);
    else
      of = (a[7] == bx[7]) && (full[7] != a[7]);
  end

endmodule

// File: rtl/alu_bitlog.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational bitwise logic on the low 16 operand bits.
// The core clears CF, OF and AF for these operations.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module alu_bitlog (
  alu_op_if.unit ops,
  output logic [15:0] res
);
  import alu_pkg::*;

  always_comb begin
    case (ops.op)
      OP_AND:  res = ops.x[15:0] & ops.y;
      OP_OR:   res = ops.x[15:0] | ops.y;
      OP_XOR:  res = ops.x[15:0] ^ ops.y;
      // NOT ignores y entirely.
      OP_NOT:  res = ~ops.x[15:0];
      default: res = '0;
    endcase
  end

endmodule

// File: rtl/alu_core.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU core: one operation at a time, no handshake.
// done comes 1 cycle after issue, DIV_STEPS+1 cycles for DIV.
// Issue while busy is illegal and is not queued.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module alu_core (
  input  logic              clk,
  input  logic              reset,
  input  logic              issue,
  input  alu_pkg::alu_op_e  op,
  input  logic [31:0]       x,
  input  logic [15:0]       y,
  input  logic              word_op,
  input  logic [15:0]       flags_cur,
  output logic [31:0]       result,
  output logic              done,
  output logic              busy,
  output logic              div_exc,
  output logic              flags_update,
  output logic [15:0]       flags_next
);
  import alu_pkg::*;
  import flags_pkg::*;

  alu_op_if opif ();

  logic [15:0] sum, log_res, sr_res, r16;
  logic [31:0] md_res, res_sel;
  logic        as_cf, as_af, as_of, sr_cf, sr_of, md_cf, md_of;
  logic        md_exc, md_ready;
  logic        pend, wait_div, accept, finish;
  logic        cf_n, af_n, of_n, keep_all, keep_psz;
  logic [15:0] fl;
  alu_group_e  grp;

  alu_addsub       addsub_inst  (.ops(opif), .sum(sum), .cf(as_cf), .af(as_af), .of(as_of));
  alu_bitlog       bitlog_inst  (.ops(opif), .res(log_res));
  alu_shift_rotate shrot_inst   (.ops(opif), .res(sr_res), .cf(sr_cf), .of(sr_of));
  alu_muldiv       muldiv_inst  (.clk(clk), .reset(reset), .ops(opif), .start(pend),
                                 .prod_quot(md_res), .cf(md_cf), .of(md_of),
                                 .exc(md_exc), .ready(md_ready));

  assign accept = issue && !busy;
  // Results are taken in the cycle after issue, or when the divider is ready.
  assign finish = (pend && opif.op != OP_DIV) || (wait_div && md_ready);

  // Operands sit in the interface until the next accepted issue.
  always_ff @(posedge clk) begin
    if (accept) begin
      opif.x       <= x;
      opif.y       <= y;
      opif.op      <= op;
      opif.word_op <= word_op;
      opif.cfi     <= flags_cur[FLAG_CF];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pend         <= 1'b0;
      wait_div     <= 1'b0;
      busy         <= 1'b0;
      done         <= 1'b0;
      div_exc      <= 1'b0;
      flags_update <= 1'b0;
      result       <= '0;
      flags_next   <= FLAGS_RESET;
    end else begin
      pend         <= accept;
      done         <= finish;
      flags_update <= finish;
      div_exc      <= finish && wait_div && md_exc;
      if (pend && opif.op == OP_DIV)
        wait_div <= 1'b1;
      else if (md_ready)
        wait_div <= 1'b0;
      // Busy stays up through the done cycle.
      if (accept)
        busy <= 1'b1;
      else if (done)
        busy <= 1'b0;
      if (finish) begin
        result     <= res_sel;
        // An exception leaves the flags word as it was.
        flags_next <= (wait_div && md_exc) ? flags_cur : fl;
      end
    end
  end

  // Result and flag selection by unit group.
  always_comb begin
    grp = op_group(opif.op);
    case (grp)
      GRP_ADDSUB: r16 = sum;
      GRP_LOGIC:  r16 = log_res;
      default:    r16 = sr_res;
    endcase
    if (!opif.word_op)
      r16[15:8] = 8'd0;
    res_sel = (grp == GRP_MULDIV) ? md_res : {16'd0, r16};

    cf_n = flags_cur[FLAG_CF];
    af_n = flags_cur[FLAG_AF];
    of_n = flags_cur[FLAG_OF];
    case (grp)
      GRP_ADDSUB: begin
        // INC and DEC keep the old carry.
        if (opif.op != OP_INC && opif.op != OP_DEC)
          cf_n = as_cf;
        af_n = as_af;
        of_n = as_of;
      end
      GRP_LOGIC: begin
        cf_n = 1'b0;
        af_n = 1'b0;
        of_n = 1'b0;
      end
      GRP_SHIFT, GRP_ROTATE: begin
        cf_n = sr_cf;
        of_n = sr_of;
      end
      default: begin
        cf_n = md_cf;
        of_n = md_of;
      end
    endcase

    keep_all = (opif.op == OP_NOT)
            || ((grp == GRP_SHIFT || grp == GRP_ROTATE) && opif.y[4:0] == 5'd0);
    // Rotates and multiply/divide touch only CF and OF.
    keep_psz = keep_all || grp == GRP_ROTATE || grp == GRP_MULDIV;

    fl = flags_cur;
    if (!keep_all) begin
      fl[FLAG_CF] = cf_n;
      fl[FLAG_AF] = af_n;
      fl[FLAG_OF] = of_n;
    end
    if (!keep_psz) begin
      fl[FLAG_PF] = ~^r16[7:0];
      fl[FLAG_ZF] = opif.word_op ? (r16 == 16'd0) : (r16[7:0] == 8'd0);
      fl[FLAG_SF] = opif.word_op ? r16[15] : r16[7];
    end
  end

  assert property (@(posedge clk) disable iff (reset) issue |-> !busy)
    else $error("Operation issued while the ALU was busy");

endmodule

// File: rtl/alu_flags_reg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Architectural flags register, reset to 16'h0002.
// Load and update in the same cycle is illegal.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module alu_flags_reg (
  input  logic        clk,
  input  logic        reset,
  input  logic        flags_load,
  input  logic [15:0] flags_in,
  input  logic        flags_update,
  input  logic [15:0] flags_next,
  output logic [15:0] flags
);
  import flags_pkg::*;

  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= FLAGS_RESET;
    end else if (flags_load) begin
      // Whole-word load, as POPF does; the reserved bit still reads one.
      flags <= flags_in | (16'd1 << FLAG_RSV1);
    end else if (flags_update) begin
      // The ALU only owns the status bits.
      flags <= (flags & ~STATUS_MASK) | (flags_next & STATUS_MASK);
    end
  end

  assert property (@(posedge clk) disable iff (reset) !(flags_load && flags_update))
    else $error("Flags load collided with an ALU update");

endmodule

// File: rtl/alu_muldiv.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multiplier and sequential restoring divider, unsigned only.
// Divide always runs DIV_STEPS iterations, even on an exception.
// start must not arrive while a divide is in progress.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module alu_muldiv (
  input  logic        clk,
  input  logic        reset,
  alu_op_if.unit      ops,
  input  logic        start,
  output logic [31:0] prod_quot,
  output logic        cf,
  output logic        of,
  output logic        exc,
  output logic        ready
);
  import alu_pkg::*;

  logic [31:0] sa, sb, prod;
  logic [15:0] hi, lo, dvs, upper;
  logic [15:0] rem, quo, rem_in, quo_in;
  logic [16:0] trial;
  logic [4:0]  cnt;
  logic        active, is_md, is_div, ovf;

  assign is_md  = (op_group(ops.op) == GRP_MULDIV);
  assign is_div = (ops.op == OP_DIV);

  // Operands are sign or zero extended so one 32-bit product serves all.
  always_comb begin
    if (ops.op == OP_IMUL) begin
      sa = ops.word_op ? 32'($signed(ops.x[15:0])) : 32'($signed(ops.x[7:0]));
      sb = ops.word_op ? 32'($signed(ops.y)) : 32'($signed(ops.y[7:0]));
    end else begin
      sa = ops.word_op ? {16'd0, ops.x[15:0]} : {24'd0, ops.x[7:0]};
      sb = ops.word_op ? {16'd0, ops.y} : {24'd0, ops.y[7:0]};
    end
    prod = sa * sb;
    if (!ops.word_op)
      prod[31:16] = '0;
    // Upper half compared against the extension of the lower half.
    upper = ops.word_op ? prod[31:16] : {8'd0, prod[15:8]};
    if (ops.op == OP_IMUL)
      ovf = ops.word_op ? (upper != {16{prod[15]}}) : (prod[15:8] != {8{prod[7]}});
    else
      ovf = (upper != 16'd0);
  end

  // A byte divide is run as a word divide of a 16-bit dividend.
  assign hi  = ops.word_op ? ops.x[31:16] : 16'd0;
  assign lo  = ops.x[15:0];
  assign dvs = ops.word_op ? ops.y : {8'd0, ops.y[7:0]};

  // One restoring step: shift in the next dividend bit, subtract if it fits.
  assign rem_in = start ? hi : rem;
  assign quo_in = start ? lo : quo;
  assign trial  = {rem_in, quo_in[15]};

  always_ff @(posedge clk) begin
    if (reset) begin
      active <= 1'b0;
      cnt    <= '0;
      exc    <= 1'b0;
    end else if (start && is_div) begin
      active <= 1'b1;
      cnt    <= 5'(DIV_STEPS - 1);
      // Zero divisor also fails this test, since hi is never negative.
      exc    <= ops.word_op ? (ops.x[31:16] >= dvs) : ({8'd0, ops.x[15:8]} >= dvs);
    end else if (active) begin
      if (cnt == 5'd0)
        active <= 1'b0;
      else
        cnt <= cnt - 5'd1;
    end
  end

  // Remainder and quotient shift one bit per divider step.
  always_ff @(posedge clk) begin
    if ((start && is_div) || (active && cnt != 5'd0)) begin
      if (trial >= {1'b0, dvs}) begin
        rem <= 16'(trial - {1'b0, dvs});
        quo <= {quo_in[14:0], 1'b1};
      end else begin
        rem <= trial[15:0];
        quo <= {quo_in[14:0], 1'b0};
      end
    end
  end

  assign ready = active && (cnt == 5'd0);
  // Remainder goes in the upper half of the active width.
  assign prod_quot = !is_div ? prod
                   : ops.word_op ? {rem, quo} : {16'd0, rem[7:0], quo[7:0]};
  assign cf = is_md && !is_div && ovf;
  assign of = cf;

  assert property (@(posedge clk) disable iff (reset) start |-> !active)
    else $error("Divider restarted while busy");

endmodule

// File: rtl/alu_op_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Registered operands shared by the ALU functional units.
// Values are stable from issue until the next issue.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

interface alu_op_if;
  import alu_pkg::*;

  logic [31:0] x;
  logic [15:0] y;
  alu_op_e     op;
  logic        word_op;
  // Carry flag as it was when the operation was issued.
  logic        cfi;

  modport core (output x, y, op, word_op, cfi);
  modport unit (input x, y, op, word_op, cfi);

endinterface

// File: rtl/alu_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operation encodings for the 16-bit ALU.
// Signed divide, BCD adjust and conversions are not encoded.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package alu_pkg;

  // One code per operation, grouped by functional unit.
  typedef enum logic [4:0] {
    OP_ADD, OP_ADC, OP_SUB, OP_SBB, OP_INC, OP_DEC,
    OP_AND, OP_OR, OP_XOR, OP_NOT,
    OP_SHL, OP_SHR, OP_SAR,
    OP_ROL, OP_ROR, OP_RCL, OP_RCR,
    OP_MUL, OP_IMUL, OP_DIV
  } alu_op_e;

  typedef enum logic [2:0] {
    GRP_ADDSUB, GRP_LOGIC, GRP_SHIFT, GRP_ROTATE, GRP_MULDIV
  } alu_group_e;

  // Number of restoring divider iterations, for byte and word alike.
  localparam int DIV_STEPS = 16;

  // Maps an opcode to the unit that executes it.
  function automatic alu_group_e op_group(alu_op_e op);
    if (op <= OP_DEC) return GRP_ADDSUB;
    if (op <= OP_NOT) return GRP_LOGIC;
    if (op <= OP_SAR) return GRP_SHIFT;
    if (op <= OP_RCR) return GRP_ROTATE;
    return GRP_MULDIV;
  endfunction

endpackage

// File: rtl/alu_shift_rotate.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational shifts and rotates with a 5-bit count from y.
// A zero count is handled by the core, which keeps all flags.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module alu_shift_rotate (
  alu_op_if.unit ops,
  output logic [15:0] res,
  output logic        cf,
  output logic        of
);
  import alu_pkg::*;

  logic [15:0] a;
  logic [4:0]  cnt, rc, n17, n9;
  logic [31:0] shl, rv, rsh, dw, rl, rr;
  logic [33:0] d17, rcl17, rcr17;
  logic [17:0] d9, rcl9, rcr9;
  logic        msb, msb2;

  always_comb begin
    a   = ops.x[15:0];
    cnt = ops.y[4:0];
    // Left shift keeps the operand low; the bit above it is the last out.
    shl = {16'd0, a} << cnt;
    // Right shifts place the operand at the top so the sign fills from bit 31.
    rv  = ops.word_op ? {a, 16'd0} : {a[7:0], 24'd0};
    rsh = (ops.op == OP_SAR) ? 32'($signed(rv) >>> cnt) : rv >> cnt;
    // Plain rotates take the count modulo the width.
    rc = ops.word_op ? {1'b0, cnt[3:0]} : {2'b0, cnt[2:0]};
    dw = ops.word_op ? {a, a} : {16'd0, a[7:0], a[7:0]};
    rl = dw << rc;
    rr = dw >> rc;
    // Rotates through carry work on width plus one bits.
    n17 = cnt % 5'd17;
    n9  = cnt % 5'd9;
    d17 = {ops.cfi, a, ops.cfi, a};
    d9  = {ops.cfi, a[7:0], ops.cfi, a[7:0]};
    rcl17 = d17 << n17;
    rcr17 = d17 >> n17;
    rcl9  = d9 << n9;
    rcr9  = d9 >> n9;

    case (ops.op)
      OP_SHL: begin
        res = shl[15:0];
        cf  = ops.word_op ? shl[16] : shl[8];
      end
      OP_SHR, OP_SAR: begin
        res = ops.word_op ? rsh[31:16] : {8'd0, rsh[31:24]};
        cf  = ops.word_op ? rsh[15] : rsh[23];
      end
      OP_ROL: begin
        res = ops.word_op ? rl[31:16] : {8'd0, rl[15:8]};
        cf  = res[0];
      end
      OP_ROR: begin
        res = ops.word_op ? rr[15:0] : {8'd0, rr[7:0]};
        cf  = ops.word_op ? res[15] : res[7];
      end
      OP_RCL: begin
        res = ops.word_op ? rcl17[32:17] : {8'd0, rcl9[16:9]};
        cf  = ops.word_op ? rcl17[33] : rcl9[17];
      end
      default: begin
        // RCR, and anything else that reaches here.
        res = ops.word_op ? rcr17[15:0] : {8'd0, rcr9[7:0]};
        cf  = ops.word_op ? rcr17[16] : rcr9[8];
      end
    endcase

    msb  = ops.word_op ? res[15] : res[7];
    msb2 = ops.word_op ? res[14] : res[6];
    case (ops.op)
      OP_SHL, OP_ROL, OP_RCL: of = msb ^ cf;
      OP_SHR:                 of = ops.word_op ? a[15] : a[7];
      OP_SAR:                 of = 1'b0;
      default:                of = msb ^ msb2;
    endcase
  end

endmodule

// File: rtl/alu_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU top level with the flags register beside the core.
// The caller must sample done; it is a single-cycle pulse.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module alu_top (
  input  logic              clk,
  input  logic              reset,
  input  logic              issue,
  input  alu_pkg::alu_op_e  op,
  input  logic [31:0]       x,
  input  logic [15:0]       y,
  input  logic              word_op,
  input  logic              flags_load,
  input  logic [15:0]       flags_in,
  output logic [31:0]       result,
  output logic [15:0]       flags,
  output logic              done,
  output logic              busy,
  output logic              div_exc
);

  logic        flags_update;
  logic [15:0] flags_next;

  // The core reads the live flags word for carry-in and unchanged bits.
  alu_core core_inst (
    .clk          (clk),
    .reset        (reset),
    .issue        (issue),
    .op           (op),
    .x            (x),
    .y            (y),
    .word_op      (word_op),
    .flags_cur    (flags),
    .result       (result),
    .done         (done),
    .busy         (busy),
    .div_exc      (div_exc),
    .flags_update (flags_update),
    .flags_next   (flags_next)
  );

  alu_flags_reg flags_inst (
    .clk          (clk),
    .reset        (reset),
    .flags_load   (flags_load),
    .flags_in     (flags_in),
    .flags_update (flags_update),
    .flags_next   (flags_next),
    .flags        (flags)
  );

endmodule

// File: rtl/flags_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Layout of the 16-bit x86 flags word.
// Only the six status flags are ever computed.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package flags_pkg;

  // Bit positions of the status flags.
  localparam int FLAG_CF = 0;
  localparam int FLAG_PF = 2;
  localparam int FLAG_AF = 4;
  localparam int FLAG_ZF = 6;
  localparam int FLAG_SF = 7;
  localparam int FLAG_OF = 11;

  // Bit 1 is reserved and always reads as one.
  localparam int FLAG_RSV1 = 1;

  // Ones at every status position; the rest are control or reserved bits.
  localparam logic [15:0] STATUS_MASK = 16'h08D5;

  // Value of the flags word after reset.
  localparam logic [15:0] FLAGS_RESET = 16'h0002;

endpackage

// File: verification/alu_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for alu_top with a bit-serial model.
// The result after a divide exception is not checked.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module alu_tb;
  import alu_pkg::*;
  import flags_pkg::*;

  // Upper bound on the operations issued over the whole run.
  localparam int MAX_OPS = 160;
  // The longest operation takes DIV_STEPS+1 cycles, the rest is slack.
  localparam int CYCLES_PER_OP = DIV_STEPS + 9;

  logic        clk, reset, issue, word_op, flags_load;
  alu_op_e     op;
  logic [31:0] x, result;
  logic [15:0] y, flags_in, flags;
  logic        done, busy, div_exc;
  int          errors;
  // Flags word as the model expects the DUT to hold it.
  logic [15:0] model_flags;

  alu_top alu_top_inst (
    .clk(clk), .reset(reset), .issue(issue), .op(op), .x(x), .y(y),
    .word_op(word_op), .flags_load(flags_load), .flags_in(flags_in),
    .result(result), .flags(flags), .done(done), .busy(busy), .div_exc(div_exc)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
      else begin
        errors++;
        $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      end
  endtask

  // Reference model. Shifts and rotates step one bit at a time.
  task automatic model_op(input alu_op_e o, input logic [31:0] xv, input logic [15:0] yv,
                          input logic w, input logic [15:0] fin,
                          output logic [31:0] r, output logic [15:0] fo, output logic exc);
    int          wd, n, i;
    logic [31:0] mask, a, b, c, v, sa, sb, dnd;
    logic        cf, af, of, msb_in, t1, pzs, keep_all;
    wd       = w ? 16 : 8;
    mask     = w ? 32'hFFFF : 32'hFF;
    a        = xv & mask;
    b        = {16'd0, yv} & mask;
    n        = yv[4:0];
    cf       = fin[FLAG_CF];
    af       = fin[FLAG_AF];
    of       = fin[FLAG_OF];
    fo       = fin;
    exc      = 1'b0;
    r        = '0;
    pzs      = 1'b1;
    keep_all = 1'b0;
    v        = a;
    case (o)
      OP_ADD, OP_ADC, OP_INC, OP_SUB, OP_SBB, OP_DEC: begin
        if (o == OP_INC || o == OP_DEC)
          b = 32'd1;
        c = (o == OP_ADC || o == OP_SBB) ? {31'd0, fin[FLAG_CF]} : 32'd0;
        if (o == OP_ADD || o == OP_ADC || o == OP_INC) begin
          r  = (a + b + c) & mask;
          af = ((a & 15) + (b & 15) + c) > 15;
          of = (a[wd-1] == b[wd-1]) && (r[wd-1] != a[wd-1]);
          if (o != OP_INC)
            cf = (a + b + c) > mask;
        end else begin
          // Borrow out of the nibble and out of the whole width.
          r  = (a - b - c) & mask;
          af = (a & 15) < (b & 15) + c;
          of = (a[wd-1] != b[wd-1]) && (r[wd-1] != a[wd-1]);
          if (o != OP_DEC)
            cf = a < b + c;
        end
      end
      OP_AND, OP_OR, OP_XOR, OP_NOT: begin
        r        = (o == OP_AND) ? a & b : (o == OP_OR) ? a | b : (o == OP_XOR) ? a ^ b : ~a;
        r        = r & mask;
        cf       = 1'b0;
        af       = 1'b0;
        of       = 1'b0;
        keep_all = (o == OP_NOT);
      end
      OP_SHL, OP_SHR, OP_SAR: begin
        msb_in = a[wd-1];
        for (i = 0; i < n; i++) begin
          if (o == OP_SHL) begin
            cf = v[wd-1];
            v  = (v << 1) & mask;
          end else begin
            cf = v[0];
            v  = (v >> 1) | ((o == OP_SAR) ? (32'(msb_in) << (wd - 1)) : 32'd0);
          end
        end
        r        = v;
        of       = (o == OP_SHL) ? (v[wd-1] ^ cf) : (o == OP_SHR) ? msb_in : 1'b0;
        keep_all = (n == 0);
      end
      OP_ROL, OP_ROR: begin
        for (i = 0; i < n % wd; i++)
          v = (o == OP_ROL) ? ((v << 1) | v[wd-1]) & mask : (v >> 1) | (32'(v[0]) << (wd - 1));
        // Even a full-turn rotate reports the bit that ends up at the edge.
        cf       = (o == OP_ROL) ? v[0] : v[wd-1];
        of       = (o == OP_ROL) ? (v[wd-1] ^ cf) : (v[wd-1] ^ v[wd-2]);
        r        = v;
        pzs      = 1'b0;
        keep_all = (n == 0);
      end
      OP_RCL, OP_RCR: begin
        for (i = 0; i < n % (wd + 1); i++) begin
          t1 = (o == OP_RCL) ? v[wd-1] : v[0];
          v  = (o == OP_RCL) ? ((v << 1) | cf) & mask : (v >> 1) | (32'(cf) << (wd - 1));
          cf = t1;
        end
        of       = (o == OP_RCL) ? (v[wd-1] ^ cf) : (v[wd-1] ^ v[wd-2]);
        r        = v;
        pzs      = 1'b0;
        keep_all = (n == 0);
      end
      OP_MUL, OP_IMUL: begin
        sa = (o == OP_MUL) ? a : w ? {{16{a[15]}}, a[15:0]} : {{24{a[7]}}, a[7:0]};
        sb = (o == OP_MUL) ? b : w ? {{16{b[15]}}, b[15:0]} : {{24{b[7]}}, b[7:0]};
        r  = sa * sb;
        // The product overflows when the lower half alone cannot represent it.
        if (o == OP_MUL)
          of = (r >> wd) != 0;
        else
          of = w ? (r != {{16{r[15]}}, r[15:0]}) : (r != {{24{r[7]}}, r[7:0]});
        if (!w)
          r = r & 32'hFFFF;
        cf  = of;
        pzs = 1'b0;
      end
      default: begin
        dnd = w ? xv : {16'd0, xv[15:0]};
        if (b == 0)
          exc = 1'b1;
        else
          exc = (dnd / b) > mask;
        if (!exc)
          r = ((dnd % b) << wd) | (dnd / b);
        cf       = 1'b0;
        of       = 1'b0;
        pzs      = 1'b0;
        keep_all = exc;
      end
    endcase
    if (!keep_all) begin
      fo[FLAG_CF] = cf;
      fo[FLAG_AF] = af;
      fo[FLAG_OF] = of;
      if (pzs) begin
        fo[FLAG_PF] = ~^r[7:0];
        fo[FLAG_ZF] = (r == 0);
        fo[FLAG_SF] = r[wd-1];
      end
    end
  endtask

  // Issues one operation and checks timing, result, exception and flags.
  task automatic do_op(input alu_op_e op_i, input logic [31:0] x_i, input logic [15:0] y_i,
                       input logic w_i);
    logic [31:0] exp_res;
    logic [15:0] exp_fl;
    logic        exp_exc;
    int          lat;
    model_op(op_i, x_i, y_i, w_i, model_flags, exp_res, exp_fl, exp_exc);
    @(posedge clk);
    issue   <= 1'b1;
    op      <= op_i;
    x       <= x_i;
    y       <= y_i;
    word_op <= w_i;
    @(posedge clk);
    issue <= 1'b0;
    lat = 0;
    @(negedge clk);
    while (!done && lat < 20) begin
      check_value({op_i.name(), " busy"}, busy, 1'b1);
      @(negedge clk);
      lat++;
    end
    assert (done)
      else begin
        errors++;
        $display("Timeout at %0t: done never arrived for %s", $time, op_i.name());
      end
    if (done) begin
      check_value({op_i.name(), " latency"}, lat, (op_i == OP_DIV) ? DIV_STEPS + 1 : 1);
      check_value({op_i.name(), " busy"}, busy, 1'b1);
      check_value({op_i.name(), " div_exc"}, div_exc, exp_exc);
      if (!exp_exc)
        check_value({op_i.name(), " result"}, result, exp_res);
      // The flags register takes the update one cycle after done.
      @(negedge clk);
      check_value({op_i.name(), " done"}, done, 1'b0);
      check_value({op_i.name(), " busy"}, busy, 1'b0);
      check_value({op_i.name(), " flags"}, flags, exp_fl);
      model_flags = exp_fl;
    end
  endtask

  // Loads a whole flags word as POPF would and checks the read-back.
  task automatic load_flags(input logic [15:0] w);
    @(posedge clk);
    flags_load <= 1'b1;
    flags_in   <= w;
    @(posedge clk);
    flags_load <= 1'b0;
    @(negedge clk);
    model_flags = w | 16'h0002;
    check_value("flags", flags, model_flags);
  endtask

  task automatic test_reset_load();
    check_value("flags", flags, model_flags);
    check_value("done", done, 1'b0);
    check_value("busy", busy, 1'b0);
    repeat (2)
      load_flags(16'($urandom));
  endtask

  task automatic test_addsub();
    int k, i;
    do_op(OP_ADD, 32'h0000FFFF, 16'h0001, 1'b1);
    do_op(OP_ADD, 32'h0000007F, 16'h0001, 1'b0);
    do_op(OP_INC, 32'h0000FFFF, 16'h0000, 1'b1);
    do_op(OP_DEC, 32'h00000080, 16'h0000, 1'b0);
    for (k = OP_ADD; k <= OP_DEC; k++)
      for (i = 0; i < 6; i++)
        do_op(alu_op_e'(k), $urandom, 16'($urandom), i[0]);
  endtask

  task automatic test_logic_shift();
    int         k, i;
    logic [4:0] cnt;
    for (k = OP_AND; k <= OP_NOT; k++)
      for (i = 0; i < 4; i++)
        do_op(alu_op_e'(k), $urandom, 16'($urandom), i[0]);
    for (k = OP_SHL; k <= OP_SAR; k++)
      for (i = 0; i < 6; i++) begin
        cnt = (i < 2) ? 5'd0 : (i < 4) ? 5'd1 : 5'($urandom);
        do_op(alu_op_e'(k), $urandom, {11'($urandom), cnt}, i[0]);
      end
  endtask

  task automatic test_rotate();
    int         k, i;
    logic [4:0] cnt;
    for (k = OP_ROL; k <= OP_RCR; k++)
      for (i = 0; i < 8; i++) begin
        // Counts 0, 1, width+1 and random, each at byte and word width.
        case (i >> 1)
          0:       cnt = 5'd0;
          1:       cnt = 5'd1;
          2:       cnt = i[0] ? 5'd17 : 5'd9;
          default: cnt = 5'($urandom);
        endcase
        do_op(alu_op_e'(k), $urandom, {11'($urandom), cnt}, i[0]);
      end
  endtask

  task automatic test_muldiv();
    int          k, i;
    logic [15:0] dv;
    do_op(OP_MUL, 32'h0000FFFF, 16'hFFFF, 1'b1);
    do_op(OP_IMUL, 32'h00000080, 16'h0080, 1'b0);
    for (k = OP_MUL; k <= OP_IMUL; k++)
      for (i = 0; i < 6; i++)
        do_op(alu_op_e'(k), $urandom, 16'($urandom), i[0]);
    // Valid divides keep the upper dividend half below the divisor.
    for (i = 0; i < 8; i++) begin
      dv = i[0] ? 16'($urandom) : {8'($urandom), 8'($urandom)};
      if (i[0] && dv == 0)
        dv = 16'd1;
      if (!i[0] && dv[7:0] == 0)
        dv[7:0] = 8'd1;
      if (i[0])
        do_op(OP_DIV, {16'($urandom % dv), 16'($urandom)}, dv, 1'b1);
      else
        do_op(OP_DIV, {16'($urandom), 8'($urandom % dv[7:0]), 8'($urandom)}, dv, 1'b0);
    end
  endtask

  task automatic test_div_exc();
    // All status flags start set, so a divide that wrongly writes CF or OF shows up.
    load_flags(16'h08D5);
    do_op(OP_DIV, 32'h12345678, 16'h0000, 1'b1);
    do_op(OP_DIV, 32'h00001234, 16'hFF00, 1'b0);
    do_op(OP_DIV, 32'h80000000, 16'h8000, 1'b1);
    do_op(OP_DIV, 32'h00000100, 16'h0001, 1'b0);
  endtask

  initial begin
    repeat (MAX_OPS * CYCLES_PER_OP + 100) @(posedge clk);
    $display("Watchdog expired before the tests completed");
    $display("Test failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h921b86ad));
    errors      = 0;
    model_flags = 16'h0002;
    reset      <= 1'b1;
    issue      <= 1'b0;
    op         <= OP_ADD;
    x          <= '0;
    y          <= '0;
    word_op    <= 1'b0;
    flags_load <= 1'b0;
    flags_in   <= '0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    test_reset_load();
    test_addsub();
    test_logic_shift();
    test_rotate();
    test_muldiv();
    test_div_exc();
    $display("Summary: %0d errors", errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule
